/* run_sim.sh */
#!/usr/bin/env bash
# build and run the calculator testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --assert --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module cal_top_tb -f vlog.f -o cal_sim &&
./obj_dir/cal_sim | tee /dev/stderr | grep -q "Test completed successfully" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* src/alu_execute.sv */
// alu_execute: single-cycle add, subtract, multiply, divide with range checks
module alu_execute (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic signed [calc_pkg::OPERAND_WIDTH-1:0] operand_a,
    input  logic signed [calc_pkg::OPERAND_WIDTH-1:0] operand_b,
    input  logic [calc_pkg::NUM_OPS-1:0]              op_sel,
    input  logic                                      conv_valid,
    output logic [calc_pkg::MAG_WIDTH-1:0]            result_mag,
    output logic                                      result_neg,
    output logic                                      result_invalid,
    output logic                                      exe_valid
);

    localparam int PW = calc_pkg::PRODUCT_WIDTH;

    logic signed [PW-1:0] wide_a;
    logic signed [PW-1:0] wide_b;
    logic signed [PW-1:0] divisor;
    logic signed [PW-1:0] value;
    logic signed [PW-1:0] magnitude;
    logic div_zero;

    assign wide_a = operand_a;
    assign wide_b = operand_b;
    assign div_zero = op_sel[calc_pkg::OP_DIV] && (operand_b == '0);
    // keep the divider defined on a zero divisor, result is flagged anyway
    assign divisor = div_zero ? PW'(1) : wide_b;

    always_comb begin
        if (op_sel[calc_pkg::OP_ADD]) begin
            value = wide_a + wide_b;
        end else if (op_sel[calc_pkg::OP_SUB]) begin
            value = wide_a - wide_b;
        end else if (op_sel[calc_pkg::OP_MUL]) begin
            value = wide_a * wide_b;
        end else begin
            value = wide_a / divisor;
        end
        magnitude = (value < 0) ? -value : value;
    end

    always_ff @(posedge clk) begin
        if (conv_valid) begin
            result_mag <= magnitude[calc_pkg::MAG_WIDTH-1:0];
            result_neg <= (value < 0);
            result_invalid <= (op_sel == '0) || div_zero || (magnitude > calc_pkg::RESULT_MAX);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= conv_valid;
        end
    end

endmodule

/* src/bin_to_bcd.sv */
// bin_to_bcd: serial shift-and-add-3 conversion of the result magnitude
module bin_to_bcd (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic [calc_pkg::MAG_WIDTH-1:0]                        result_mag,
    input  logic                                                  result_neg,
    input  logic                                                  result_invalid,
    input  logic                                                  exe_valid,
    output logic [calc_pkg::ENTRY_DIGITS*calc_pkg::DIGIT_WIDTH-1:0] bcd_digits,
    output logic                                                  bcd_neg,
    output logic                                                  bcd_invalid,
    output logic                                                  result_done
);

    localparam int CNT_W = $clog2(calc_pkg::MAG_WIDTH + 1);

    calc_pkg::bcd_shift_t shift_q;
    calc_pkg::bcd_shift_t shift_d;
    logic [CNT_W-1:0] shift_cnt;

    // add 3 to digits of five or more, then shift
    always_comb begin
        shift_d = shift_q;
        for (int i = 0; i < calc_pkg::ENTRY_DIGITS; i++) begin
            if (shift_d.fields.bcd[i] >= 4'd5) begin
                shift_d.fields.bcd[i] = shift_d.fields.bcd[i] + 4'd3;
            end
        end
        shift_d.raw = shift_d.raw << 1;
    end

    always_ff @(posedge clk) begin
        if (exe_valid) begin
            shift_q.fields.bcd <= '0;
            shift_q.fields.bin <= result_mag;
            bcd_neg <= result_neg;
            bcd_invalid <= result_invalid;
        end else if (shift_cnt != '0) begin
            shift_q <= shift_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_cnt <= '0;
            result_done <= 1'b0;
        end else begin
            result_done <= (shift_cnt == CNT_W'(1));
            if (exe_valid) begin
                shift_cnt <= CNT_W'(calc_pkg::MAG_WIDTH);
            end else if (shift_cnt != '0) begin
                shift_cnt <= shift_cnt - 1'b1;
            end
        end
    end

    assign bcd_digits = shift_q.fields.bcd;

endmodule

/* src/button_conditioner.sv */
// button_conditioner: per-button debounce, press pulse and priority mask
module button_conditioner #(
    parameter int DEBOUNCE_CYCLES = 1048576
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [calc_pkg::BUTTON_WIDTH-1:0] buttons,
    output logic [calc_pkg::BUTTON_WIDTH-1:0] press
);

    localparam int BW = calc_pkg::BUTTON_WIDTH;
    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [BW-1:0][CNT_W-1:0] stable_cnt;
    logic [BW-1:0] level;
    logic [BW-1:0] rise;

    // counts cycles where the input disagrees with the debounced level
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stable_cnt <= '0;
            level <= '0;
            rise <= '0;
        end else begin
            for (int i = 0; i < BW; i++) begin
                rise[i] <= 1'b0;
                if (buttons[i] == level[i]) begin
                    stable_cnt[i] <= '0;
                end else if (stable_cnt[i] == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                    stable_cnt[i] <= '0;
                    level[i] <= buttons[i];
                    rise[i] <= buttons[i];
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

    // lowest index wins
    assign press = rise & (~rise + 1'b1);

endmodule

/* src/cal_top.sv */
// cal_top: calculator top level connecting entry, conversion, execute and display
module cal_top #(
    parameter int DEBOUNCE_CYCLES = 2**20,
    parameter int SCAN_DIV_BITS = 10
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [calc_pkg::BUTTON_WIDTH-1:0] board_cal_button,
    input  logic [calc_pkg::NUM_OPS-1:0]      board_cal_switchs,
    output logic [3:0]                        cal_board_digit_ctrl,
    output logic [7:0]                        cal_board_digit_seg,
    output logic                              cal_board_exe_done
);

    localparam int DV = calc_pkg::ENTRY_DIGITS * calc_pkg::DIGIT_WIDTH;

    logic [calc_pkg::BUTTON_WIDTH-1:0] press;
    logic entering;
    logic [DV-1:0] entry_digits;
    logic entry_sign;
    logic [DV-1:0] a_digits;
    logic a_sign;
    logic [DV-1:0] b_digits;
    logic b_sign;
    logic [calc_pkg::NUM_OPS-1:0] op_sel;
    logic operands_valid;
    logic signed [calc_pkg::OPERAND_WIDTH-1:0] operand_a;
    logic signed [calc_pkg::OPERAND_WIDTH-1:0] operand_b;
    logic conv_valid;
    logic [calc_pkg::MAG_WIDTH-1:0] result_mag;
    logic result_neg;
    logic result_invalid;
    logic exe_valid;
    logic [DV-1:0] bcd_digits;
    logic bcd_neg;
    logic bcd_invalid;
    logic result_done;

    button_conditioner #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) button_conditioner_i (
        .clk(clk), .rst_n(rst_n), .buttons(board_cal_button), .press(press)
    );

    operand_entry operand_entry_i (
        .clk(clk), .rst_n(rst_n), .press(press), .switches(board_cal_switchs),
        .result_done(result_done), .entering(entering), .entry_digits(entry_digits),
        .entry_sign(entry_sign), .a_digits(a_digits), .a_sign(a_sign),
        .b_digits(b_digits), .b_sign(b_sign), .op_sel(op_sel),
        .operands_valid(operands_valid), .exe_done(cal_board_exe_done)
    );

    dec_to_bin dec_to_bin_i (
        .clk(clk), .rst_n(rst_n), .a_digits(a_digits), .a_sign(a_sign),
        .b_digits(b_digits), .b_sign(b_sign), .operands_valid(operands_valid),
        .operand_a(operand_a), .operand_b(operand_b), .conv_valid(conv_valid)
    );

    alu_execute alu_execute_i (
        .clk(clk), .rst_n(rst_n), .operand_a(operand_a), .operand_b(operand_b),
        .op_sel(op_sel), .conv_valid(conv_valid), .result_mag(result_mag),
        .result_neg(result_neg), .result_invalid(result_invalid), .exe_valid(exe_valid)
    );

    bin_to_bcd bin_to_bcd_i (
        .clk(clk), .rst_n(rst_n), .result_mag(result_mag), .result_neg(result_neg),
        .result_invalid(result_invalid), .exe_valid(exe_valid), .bcd_digits(bcd_digits),
        .bcd_neg(bcd_neg), .bcd_invalid(bcd_invalid), .result_done(result_done)
    );

    seg_display #(.SCAN_DIV_BITS(SCAN_DIV_BITS)) seg_display_i (
        .clk(clk), .rst_n(rst_n), .entering(entering), .exe_done(cal_board_exe_done),
        .entry_digits(entry_digits), .entry_sign(entry_sign), .bcd_digits(bcd_digits),
        .bcd_neg(bcd_neg), .bcd_invalid(bcd_invalid),
        .digit_ctrl(cal_board_digit_ctrl), .digit_seg(cal_board_digit_seg)
    );

endmodule

/* src/calc_pkg.sv */
// calculator widths, button and operation indices, display codes, BCD shift word
package calc_pkg;

    localparam int BUTTON_WIDTH = 5;
    localparam int BTN_LEFT = 0;
    localparam int BTN_RIGHT = 1;
    localparam int BTN_UP = 2;
    localparam int BTN_DOWN = 3;
    localparam int BTN_MID = 4;

    localparam int NUM_OPS = 4;
    localparam int OP_ADD = 0;
    localparam int OP_SUB = 1;
    localparam int OP_MUL = 2;
    localparam int OP_DIV = 3;

    localparam int DIGIT_WIDTH = 4;
    localparam int ENTRY_DIGITS = 3;
    localparam int OPERAND_WIDTH = 16;
    localparam int PRODUCT_WIDTH = 32;
    localparam int MAG_WIDTH = 10;
    localparam int RESULT_MAX = 999;

    localparam logic [DIGIT_WIDTH-1:0] CODE_BLANK = 4'ha;
    localparam logic [DIGIT_WIDTH-1:0] CODE_DASH = 4'hb;

    // shift-and-add-3 word, BCD digits above the binary being shifted out
    typedef union packed {
        logic [ENTRY_DIGITS*DIGIT_WIDTH+MAG_WIDTH-1:0] raw;
        struct packed {
            logic [ENTRY_DIGITS-1:0][DIGIT_WIDTH-1:0] bcd;
            logic [MAG_WIDTH-1:0] bin;
        } fields;
    } bcd_shift_t;

endpackage

/* src/dec_to_bin.sv */
// dec_to_bin: pipelined decimal to signed binary adder tree for both operands
module dec_to_bin (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic [calc_pkg::ENTRY_DIGITS*calc_pkg::DIGIT_WIDTH-1:0] a_digits,
    input  logic                                                  a_sign,
    input  logic [calc_pkg::ENTRY_DIGITS*calc_pkg::DIGIT_WIDTH-1:0] b_digits,
    input  logic                                                  b_sign,
    input  logic                                                  operands_valid,
    output logic signed [calc_pkg::OPERAND_WIDTH-1:0]             operand_a,
    output logic signed [calc_pkg::OPERAND_WIDTH-1:0]             operand_b,
    output logic                                                  conv_valid
);

    localparam int DW = calc_pkg::DIGIT_WIDTH;
    localparam int OW = calc_pkg::OPERAND_WIDTH;

    logic [1:0][calc_pkg::ENTRY_DIGITS*DW-1:0] digits;
    logic [1:0] signs;
    logic [1:0][OW-1:0] tens_q;
    logic [1:0][OW-1:0] hundreds_q;
    logic [1:0][OW-1:0] low_q;
    logic [1:0][OW-1:0] partial_q;
    logic [1:0][OW-1:0] mag_q;
    logic [1:0][OW-1:0] value_q;
    logic [3:0] vld_q;

    // index 0 is A, index 1 is B
    assign digits = {b_digits, a_digits};
    assign signs = {b_sign, a_sign};

    always_ff @(posedge clk) begin
        for (int k = 0; k < 2; k++) begin
            if (operands_valid) begin
                tens_q[k] <= (OW'(digits[k][DW +: DW]) << 3) + (OW'(digits[k][DW +: DW]) << 1);
                hundreds_q[k] <= (OW'(digits[k][2*DW +: DW]) << 6) +
                                 (OW'(digits[k][2*DW +: DW]) << 5);
                low_q[k] <= OW'(digits[k][0 +: DW]) + (OW'(digits[k][2*DW +: DW]) << 2);
            end
            if (vld_q[0]) begin
                partial_q[k] <= tens_q[k] + hundreds_q[k];
            end
            if (vld_q[1]) begin
                mag_q[k] <= partial_q[k] + low_q[k];
            end
            if (vld_q[2]) begin
                value_q[k] <= signs[k] ? -mag_q[k] : mag_q[k];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[2:0], operands_valid};
        end
    end

    assign operand_a = value_q[0];
    assign operand_b = value_q[1];
    assign conv_valid = vld_q[3];

endmodule

/* src/operand_entry.sv */
// operand_entry: phase sequencer, digit cursor, digit/sign edit, operand capture
module operand_entry (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic [calc_pkg::BUTTON_WIDTH-1:0]                     press,
    input  logic [calc_pkg::NUM_OPS-1:0]                          switches,
    input  logic                                                  result_done,
    output logic                                                  entering,
    output logic [calc_pkg::ENTRY_DIGITS*calc_pkg::DIGIT_WIDTH-1:0] entry_digits,
    output logic                                                  entry_sign,
    output logic [calc_pkg::ENTRY_DIGITS*calc_pkg::DIGIT_WIDTH-1:0] a_digits,
    output logic                                                  a_sign,
    output logic [calc_pkg::ENTRY_DIGITS*calc_pkg::DIGIT_WIDTH-1:0] b_digits,
    output logic                                                  b_sign,
    output logic [calc_pkg::NUM_OPS-1:0]                          op_sel,
    output logic                                                  operands_valid,
    output logic                                                  exe_done
);

    localparam int DW = calc_pkg::DIGIT_WIDTH;
    localparam logic [2:0] PH_IDLE = 3'd0;
    localparam logic [2:0] PH_INPUT_A = 3'd1;
    localparam logic [2:0] PH_INPUT_B = 3'd2;
    localparam logic [2:0] PH_WAIT = 3'd3;
    localparam logic [2:0] PH_DISPLAY = 3'd4;
    localparam logic [1:0] CUR_SIGN = 2'd3;

    logic [2:0] phase;
    logic [1:0] cursor;
    logic [DW-1:0] cur_digit;
    logic [calc_pkg::NUM_OPS-1:0] op_qual;
    logic btn_left;
    logic btn_right;
    logic btn_up;
    logic btn_down;
    logic btn_mid;
    logic start_entry;

    assign btn_left = press[calc_pkg::BTN_LEFT];
    assign btn_right = press[calc_pkg::BTN_RIGHT];
    assign btn_up = press[calc_pkg::BTN_UP];
    assign btn_down = press[calc_pkg::BTN_DOWN];
    assign btn_mid = press[calc_pkg::BTN_MID];

    assign entering = (phase == PH_INPUT_A) || (phase == PH_INPUT_B);
    assign exe_done = (phase == PH_DISPLAY);
    // phases that open a fresh operand
    assign start_entry = (phase == PH_IDLE) ||
                         (btn_mid && (phase == PH_INPUT_A || phase == PH_DISPLAY));

    assign cur_digit = entry_digits[cursor*DW +: DW];
    assign op_qual = switches & (~switches + 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= PH_IDLE;
            operands_valid <= 1'b0;
        end else begin
            operands_valid <= (phase == PH_INPUT_B) && btn_mid;
            case (phase)
                PH_IDLE: phase <= PH_INPUT_A;
                PH_INPUT_A: if (btn_mid) phase <= PH_INPUT_B;
                PH_INPUT_B: if (btn_mid) phase <= PH_WAIT;
                PH_WAIT: if (result_done) phase <= PH_DISPLAY;
                PH_DISPLAY: if (btn_mid) phase <= PH_INPUT_A;
                default: phase <= PH_IDLE;
            endcase
        end
    end

    // cursor moves left toward sign, right toward digit0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cursor <= 2'd0;
            entry_digits <= '0;
            entry_sign <= 1'b0;
        end else if (start_entry) begin
            cursor <= 2'd0;
            entry_digits <= '0;
            entry_sign <= 1'b0;
        end else if (entering) begin
            if (btn_left && cursor != CUR_SIGN) begin
                cursor <= cursor + 2'd1;
            end
            if (btn_right && cursor != 2'd0) begin
                cursor <= cursor - 2'd1;
            end
            if (cursor == CUR_SIGN) begin
                if (btn_up || btn_down) begin
                    entry_sign <= ~entry_sign;
                end
            end else if (btn_up) begin
                entry_digits[cursor*DW +: DW] <= (cur_digit == 4'd9) ? 4'd0 : cur_digit + 4'd1;
            end else if (btn_down) begin
                entry_digits[cursor*DW +: DW] <= (cur_digit == 4'd0) ? 4'd9 : cur_digit - 4'd1;
            end
        end
    end

    // operand capture on each mid press that closes an input phase
    always_ff @(posedge clk) begin
        if (phase == PH_INPUT_A && btn_mid) begin
            a_digits <= entry_digits;
            a_sign <= entry_sign;
        end
        if (phase == PH_INPUT_B && btn_mid) begin
            b_digits <= entry_digits;
            b_sign <= entry_sign;
            op_sel <= op_qual;
        end
    end

endmodule

/* src/seg_display.sv */
// seg_display: digit scan, leading-zero blanking and seven-segment encoding
module seg_display #(
    parameter int SCAN_DIV_BITS = 10
) (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic                                                  entering,
    input  logic                                                  exe_done,
    input  logic [calc_pkg::ENTRY_DIGITS*calc_pkg::DIGIT_WIDTH-1:0] entry_digits,
    input  logic                                                  entry_sign,
    input  logic [calc_pkg::ENTRY_DIGITS*calc_pkg::DIGIT_WIDTH-1:0] bcd_digits,
    input  logic                                                  bcd_neg,
    input  logic                                                  bcd_invalid,
    output logic [3:0]                                            digit_ctrl,
    output logic [7:0]                                            digit_seg
);

    localparam int DW = calc_pkg::DIGIT_WIDTH;

    logic [SCAN_DIV_BITS-1:0] prescale;
    logic [1:0] pos;
    logic show;
    logic d2_zero;
    logic d1_zero;
    logic [DW-1:0] code;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prescale <= '0;
            pos <= 2'd0;
        end else begin
            prescale <= prescale + 1'b1;
            if (&prescale) begin
                pos <= pos + 2'd1;
            end
        end
    end

    assign show = entering || (exe_done && !bcd_invalid);
    assign digit_ctrl = show ? ~(4'b0001 << pos) : 4'b1111;

    assign d2_zero = (bcd_digits[2*DW +: DW] == '0);
    assign d1_zero = d2_zero && (bcd_digits[DW +: DW] == '0);

    // position 3 is the sign
    always_comb begin
        case (pos)
            2'd3: begin
                if (entering) begin
                    code = entry_sign ? calc_pkg::CODE_DASH : calc_pkg::CODE_BLANK;
                end else begin
                    code = bcd_neg ? calc_pkg::CODE_DASH : calc_pkg::CODE_BLANK;
                end
            end
            2'd2: begin
                code = entering ? entry_digits[2*DW +: DW] :
                       d2_zero ? calc_pkg::CODE_BLANK : bcd_digits[2*DW +: DW];
            end
            2'd1: begin
                code = entering ? entry_digits[DW +: DW] :
                       d1_zero ? calc_pkg::CODE_BLANK : bcd_digits[DW +: DW];
            end
            default: code = entering ? entry_digits[0 +: DW] : bcd_digits[0 +: DW];
        endcase
    end

    // active low, decimal point in bit 0
    always_comb begin
        case (code)
            4'h0: digit_seg = 8'h03;
            4'h1: digit_seg = 8'h9f;
            4'h2: digit_seg = 8'h25;
            4'h3: digit_seg = 8'h0d;
            4'h4: digit_seg = 8'h99;
            4'h5: digit_seg = 8'h49;
            4'h6: digit_seg = 8'h41;
            4'h7: digit_seg = 8'h1f;
            4'h8: digit_seg = 8'h01;
            4'h9: digit_seg = 8'h19;
            calc_pkg::CODE_DASH: digit_seg = 8'hfd;
            default: digit_seg = 8'hff;
        endcase
    end

endmodule

/* test/cal_top_tb.sv */
// cal_top_tb: calculator testbench with reference model and display assertions
module cal_top_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HOLD_CYCLES = 8;
    localparam int PRESS_CYCLES = 2 * HOLD_CYCLES;
    localparam int NUM_RANDOM = 20;
    localparam int NUM_DIRECTED = 8;
    // about 42 presses per calculation plus the result wait and display hold
    localparam int CALC_CYCLES = 42 * PRESS_CYCLES + 64;
    localparam int TIMEOUT_CYCLES = 2 * (NUM_RANDOM + NUM_DIRECTED) * CALC_CYCLES;
    localparam int M_IDLE = 0;
    localparam int M_ENTRY_A = 1;
    localparam int M_ENTRY_B = 2;
    localparam int M_WAIT = 3;
    localparam int M_DISPLAY = 4;
    // codes 0 to 9, then blank, then dash
    localparam logic [7:0] SEG_TABLE [12] = '{8'h03, 8'h9f, 8'h25, 8'h0d, 8'h99, 8'h49,
                                              8'h41, 8'h1f, 8'h01, 8'h19, 8'hff, 8'hfd};

    logic clk;
    logic rst_n;
    logic [calc_pkg::BUTTON_WIDTH-1:0] buttons;
    logic [calc_pkg::NUM_OPS-1:0] switches;
    logic [3:0] digit_ctrl;
    logic [7:0] digit_seg;
    logic exe_done;
    integer seed;
    int errors = 0;
    int cycle_count = 0;
    int result_checks = 0;
    logic check_en;
    int model_phase;
    int model_cursor;
    int model_digit [3];
    logic model_sign;
    int model_a;
    int model_result;
    logic model_result_ok;
    logic show_exp;
    logic one_low;
    int scan_pos;
    logic [7:0] seg_exp;

    tb_clock #(.PERIOD_NS(20)) tb_clock_i (.clk(clk));

    cal_top #(
        .DEBOUNCE_CYCLES(4),
        .SCAN_DIV_BITS(2)
    ) cal_top_i (
        .clk(clk), .rst_n(rst_n), .board_cal_button(buttons), .board_cal_switchs(switches),
        .cal_board_digit_ctrl(digit_ctrl), .cal_board_digit_seg(digit_seg),
        .cal_board_exe_done(exe_done)
    );

    function automatic int expected_code(input int pos);
        int mag;
        int d [3];
        mag = (model_result < 0) ? -model_result : model_result;
        d[0] = mag % 10;
        d[1] = (mag / 10) % 10;
        d[2] = mag / 100;
        if (model_phase != M_DISPLAY) begin
            if (pos == 3) return model_sign ? 11 : 10;
            return model_digit[pos];
        end
        if (pos == 3) return (model_result < 0) ? 11 : 10;
        // leading zeros go dark
        if (pos == 2 && d[2] == 0) return 10;
        if (pos == 1 && d[2] == 0 && d[1] == 0) return 10;
        return d[pos];
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic int entry_value();
        int v;
        v = model_digit[0] + 10 * model_digit[1] + 100 * model_digit[2];
        return model_sign ? -v : v;
    endfunction

    assign one_low = ($countones(~digit_ctrl) == 1);

    always_comb begin
        show_exp = (model_phase == M_ENTRY_A) || (model_phase == M_ENTRY_B) ||
                   (model_phase == M_DISPLAY && model_result_ok);
        scan_pos = 0;
        for (int i = 0; i < 4; i++) begin
            if (!digit_ctrl[i]) begin
                scan_pos = i;
            end
        end
        seg_exp = SEG_TABLE[expected_code(scan_pos)];
    end

    a_exe_done: assert property (@(posedge clk) disable iff (!rst_n || !check_en)
        exe_done == (model_phase == M_DISPLAY))
    else begin
        errors++;
        $display("CHECK FAILED cal_board_exe_done expected %h actual %h",
                 model_phase == M_DISPLAY, $sampled(exe_done));
    end

    a_ctrl_dark: assert property (@(posedge clk) disable iff (!rst_n || !check_en)
        !show_exp |-> digit_ctrl == 4'hf)
    else begin
        errors++;
        $display("CHECK FAILED cal_board_digit_ctrl expected %h actual %h",
                 4'hf, $sampled(digit_ctrl));
    end

    a_ctrl_scan: assert property (@(posedge clk) disable iff (!rst_n || !check_en)
        show_exp |-> one_low)
    else begin
        errors++;
        $display("CHECK FAILED cal_board_digit_ctrl expected one low bit actual %h",
                 $sampled(digit_ctrl));
    end

    a_seg: assert property (@(posedge clk) disable iff (!rst_n || !check_en)
        show_exp && one_low |-> digit_seg == seg_exp)
    else begin
        errors++;
        $display("CHECK FAILED cal_board_digit_seg expected %h actual %h",
                 $sampled(seg_exp), $sampled(digit_seg));
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (rst_n && check_en && show_exp && one_low && model_phase == M_DISPLAY) begin
            result_checks <= result_checks + 1;
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("result digit checks: %0d, errors: %0d", result_checks, errors + 1);
            $display("Test failed");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic clear_entry();
        model_cursor = 0;
        model_digit = '{0, 0, 0};
        model_sign = 1'b0;
    endtask

    task automatic compute_result(input int a, input int b,
                                  input logic [calc_pkg::NUM_OPS-1:0] sw);
        int op;
        op = -1;
        for (int i = 0; i < calc_pkg::NUM_OPS; i++) begin
            if (sw[i] && op < 0) op = i;
        end
        model_result_ok = 1'b1;
        model_result = 0;
        case (op)
            calc_pkg::OP_ADD: model_result = a + b;
            calc_pkg::OP_SUB: model_result = a - b;
            calc_pkg::OP_MUL: model_result = a * b;
            calc_pkg::OP_DIV: begin
                if (b == 0) model_result_ok = 1'b0;
                else model_result = a / b;
            end
            default: model_result_ok = 1'b0;
        endcase
        if (model_result > calc_pkg::RESULT_MAX || model_result < -calc_pkg::RESULT_MAX) begin
            model_result_ok = 1'b0;
        end
    endtask

    task automatic apply_press(input int idx);
        logic entering;
        entering = (model_phase == M_ENTRY_A) || (model_phase == M_ENTRY_B);
        case (idx)
            calc_pkg::BTN_LEFT: if (entering && model_cursor < 3) model_cursor++;
            calc_pkg::BTN_RIGHT: if (entering && model_cursor > 0) model_cursor--;
            calc_pkg::BTN_UP, calc_pkg::BTN_DOWN: begin
                if (entering && model_cursor == 3) begin
                    model_sign = !model_sign;
                end else if (entering) begin
                    model_digit[model_cursor] = (model_digit[model_cursor] +
                                                 (idx == calc_pkg::BTN_UP ? 1 : 9)) % 10;
                end
            end
            default: begin
                if (model_phase == M_ENTRY_A) begin
                    model_a = entry_value();
                    clear_entry();
                    model_phase = M_ENTRY_B;
                end else if (model_phase == M_ENTRY_B) begin
                    compute_result(model_a, entry_value(), switches);
                    model_phase = M_WAIT;
                end else if (model_phase == M_DISPLAY) begin
                    clear_entry();
                    model_phase = M_ENTRY_A;
                end
            end
        endcase
    endtask

    // display is only checked while the button is released
    task automatic press_button(input int idx);
        check_en = 1'b0;
        buttons[idx] = 1'b1;
        repeat (HOLD_CYCLES) next_cycle();
        buttons[idx] = 1'b0;
        apply_press(idx);
        check_en = 1'b1;
        repeat (HOLD_CYCLES) next_cycle();
    endtask

    task automatic enter_operand(input int value);
        int mag;
        int d;
        mag = (value < 0) ? -value : value;
        for (int i = 0; i < 3; i++) begin
            d = mag % 10;
            mag = mag / 10;
            // short way round the digit wheel
            if (d <= 5) begin
                repeat (d) press_button(calc_pkg::BTN_UP);
            end else begin
                repeat (10 - d) press_button(calc_pkg::BTN_DOWN);
            end
            press_button(calc_pkg::BTN_LEFT);
        end
        if (value < 0) begin
            press_button(calc_pkg::BTN_UP);
        end
    endtask

    task automatic wait_result();
        int waited;
        check_en = 1'b0;
        waited = 0;
        while (!exe_done && waited < 64) begin
            next_cycle();
            waited++;
        end
        if (!exe_done) begin
            errors++;
            $display("exe_done did not rise within 64 cycles of the launch");
        end
        model_phase = M_DISPLAY;
        check_en = 1'b1;
        // more than one full scan of the result
        repeat (24) next_cycle();
    endtask

    task automatic run_calc(input int a, input int b, input logic [calc_pkg::NUM_OPS-1:0] sw);
        enter_operand(a);
        press_button(calc_pkg::BTN_MID);
        switches = sw;
        enter_operand(b);
        press_button(calc_pkg::BTN_MID);
        wait_result();
        press_button(calc_pkg::BTN_MID);
    endtask

    initial begin
        int op;
        int a;
        int b;
        logic [3:0] extra;
        logic [3:0] sw;
        seed = 32'h73d6;
        rst_n = 1'b0;
        buttons = '0;
        switches = '0;
        check_en = 1'b0;
        model_phase = M_IDLE;
        model_a = 0;
        model_result = 0;
        model_result_ok = 1'b0;
        clear_entry();
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();
        next_cycle();
        model_phase = M_ENTRY_A;
        check_en = 1'b1;
        repeat (32) next_cycle();

        // digit wrap, cursor end stops and sign toggle
        press_button(calc_pkg::BTN_DOWN);
        press_button(calc_pkg::BTN_UP);
        repeat (4) press_button(calc_pkg::BTN_LEFT);
        press_button(calc_pkg::BTN_UP);
        press_button(calc_pkg::BTN_DOWN);
        repeat (4) press_button(calc_pkg::BTN_RIGHT);
        press_button(calc_pkg::BTN_UP);
        press_button(calc_pkg::BTN_DOWN);

        run_calc(7, 2, 4'b1000);
        run_calc(-7, 2, 4'b1000);
        run_calc(-1, 5, 4'b1000);
        run_calc(5, 0, 4'b1000);
        run_calc(500, 3, 4'b0100);
        run_calc(999, 1, 4'b0001);
        run_calc(12, 34, 4'b0000);
        run_calc(-305, 305, 4'b0011);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            op = rand_range(0, 3);
            extra = 4'(rand_range(0, 15));
            // extra switches above the chosen one must lose
            sw = (4'b0001 << op) | (extra & (4'b1110 << op));
            case (op)
                calc_pkg::OP_MUL: begin
                    a = rand_range(-31, 31);
                    b = rand_range(-31, 31);
                end
                calc_pkg::OP_DIV: begin
                    a = rand_range(-999, 999);
                    b = rand_range(-20, 20);
                end
                default: begin
                    a = rand_range(-499, 499);
                    b = rand_range(-499, 499);
                end
            endcase
            run_calc(a, b, sw);
        end

        if (result_checks == 0) begin
            errors++;
            $display("no result digit was ever checked on the display");
        end
        $display("result digit checks: %0d, errors: %0d", result_checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* test/tb_clock.sv */
// tb_clock: free-running testbench clock
module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

/* vlog.f */
src/calc_pkg.sv
src/button_conditioner.sv
src/operand_entry.sv
src/dec_to_bin.sv
src/alu_execute.sv
src/bin_to_bcd.sv
src/seg_display.sv
src/cal_top.sv
test/tb_clock.sv
test/cal_top_tb.sv
